//--- saturn_alu_pkg.sv
// Shared types for the nibble-serial calculator ALU and register unit.
// Holds the word and nibble widths, the field and register-select
// structs, the operand banks and the operation encodings.
package saturn_alu_pkg;

    localparam int NIBBLES = 16;

    typedef logic [4*NIBBLES-1:0] word_t;
    typedef logic [3:0]           nib_t;        // nibble value or nibble index
    typedef logic [NIBBLES-1:0]   nib_mask_t;   // one enable per nibble

    // nibbles right..left inclusive, empty when left < right
    typedef struct packed {
        nib_t left;
        nib_t right;
    } field_t;

    typedef enum logic [1:0] {
        BANK_WORK    = 2'd0,    // A..D
        BANK_SCRATCH = 2'd1,    // R0..Rn
        BANK_MEM     = 2'd2     // data input, source only
    } bank_t;

    typedef struct packed {
        bank_t      bank;
        logic [2:0] index;      // low two bits for A..D
    } reg_sel_t;

    typedef enum logic [3:0] {
        OP_TFR  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_RSUB = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_SLN  = 4'h6,
        OP_SRN  = 4'h7,
        OP_CSL  = 4'h8,
        OP_CSR  = 4'h9,
        OP_EQ   = 4'ha,
        OP_NE   = 4'hb,
        OP_GE   = 4'hc,
        OP_GT   = 4'hd,
        OP_LE   = 4'he,
        OP_LT   = 4'hf
    } alu_op_t;

endpackage

//--- field_mask.sv
// Nibble field mask.
// Decodes the left and right nibble boundaries into a per-nibble enable
// and clears every nibble of the input word outside the field.
`timescale 1ns/1ps

module field_mask (
    input  saturn_alu_pkg::field_t    field_i,
    input  saturn_alu_pkg::word_t     word_i,
    output saturn_alu_pkg::nib_mask_t mask_o,
    output saturn_alu_pkg::word_t     word_o
);
    import saturn_alu_pkg::*;

    nib_mask_t mask;

    always_comb
    begin
        for (int n = 0; n < NIBBLES; n++)
        begin
            mask[n] = (nib_t'(n) <= field_i.left) && (nib_t'(n) >= field_i.right);
        end
    end

    always_comb
    begin
        word_o = '0;
        for (int n = 0; n < NIBBLES; n++)
        begin
            if (mask[n])
            begin
                word_o[4*n +: 4] = word_i[4*n +: 4];
            end
        end
    end

    assign mask_o = mask;

endmodule

//--- bcd_addsub64.sv
// Sixteen-nibble adder/subtractor, binary or BCD.
// Computes a+b or a-b nibble by nibble with decimal digit correction.
// The forced carry enters at the right field boundary and the reported
// carry is taken out of the left field boundary.
`timescale 1ns/1ps

module bcd_addsub64 (
    input  saturn_alu_pkg::word_t  a_i,
    input  saturn_alu_pkg::word_t  b_i,
    input  logic                   sub_i,
    input  logic                   decimal_i,
    input  logic                   forced_carry_i,
    input  saturn_alu_pkg::field_t field_i,
    output saturn_alu_pkg::word_t  q_o,
    output logic                   carry_o
);
    import saturn_alu_pkg::*;

    logic               c_in;
    logic               c_out;
    logic [4:0]         raw;        // nibble sum or difference, bit 4 is carry/borrow
    logic [3:0]         digit;
    logic [NIBBLES-1:0] nib_carry;  // carry out of each nibble

    always_comb
    begin
        q_o       = '0;
        nib_carry = '0;
        c_in      = 1'b0;
        c_out     = 1'b0;
        raw       = '0;
        digit     = '0;
        for (int i = 0; i < NIBBLES; i++)
        begin
            // forced carry joins the chain at the field's lowest nibble
            c_in = c_out | (forced_carry_i & (field_i.right == nib_t'(i)));
            if (sub_i)
            begin
                raw   = {1'b0, a_i[4*i +: 4]} - {1'b0, b_i[4*i +: 4]} - {4'h0, c_in};
                c_out = raw[4];                                 // borrow when negative
                if (decimal_i && c_out)
                begin
                    digit = raw[3:0] - 4'h6;
                end
                else
                begin
                    digit = raw[3:0];
                end
            end
            else
            begin
                raw = {1'b0, a_i[4*i +: 4]} + {1'b0, b_i[4*i +: 4]} + {4'h0, c_in};
                if (decimal_i)
                begin
                    c_out = raw > 5'd9;
                end
                else
                begin
                    c_out = raw[4];
                end
                if (decimal_i && c_out)
                begin
                    digit = raw[3:0] + 4'h6;                    // skip the six unused codes
                end
                else
                begin
                    digit = raw[3:0];
                end
            end
            q_o[4*i +: 4] = digit;
            nib_carry[i]  = c_out;
        end
    end

    assign carry_o = nib_carry[field_i.left];

endmodule

//--- nibble_compare.sv
// Nibble-wise magnitude compare of two words.
// Finds the most significant differing nibble and derives the six
// unsigned relations of a against b from it.
`timescale 1ns/1ps

module nibble_compare (
    input  saturn_alu_pkg::word_t a_i,
    input  saturn_alu_pkg::word_t b_i,
    output logic                  eq_o,
    output logic                  ne_o,
    output logic                  ge_o,
    output logic                  gt_o,
    output logic                  le_o,
    output logic                  lt_o
);
    import saturn_alu_pkg::*;

    logic found;    // a differing nibble was seen
    logic a_gt;     // a is larger at that nibble

    always_comb
    begin
        found = 1'b0;
        a_gt  = 1'b0;
        for (int i = NIBBLES - 1; i >= 0; i--)
        begin
            if (!found && (a_i[4*i +: 4] != b_i[4*i +: 4]))
            begin
                found = 1'b1;
                a_gt  = a_i[4*i +: 4] > b_i[4*i +: 4];
            end
        end
    end

    assign eq_o = ~found;
    assign ne_o = found;
    assign gt_o = found & a_gt;
    assign lt_o = found & ~a_gt;
    assign ge_o = ~found | a_gt;
    assign le_o = ~(found & a_gt);

endmodule

//--- register_file.sv
// Working and scratch register bank.
// Holds A..D and R0..R(NUM_SCRATCH-1) with two combinational read ports
// and two nibble-masked write ports; the destination write has priority
// over the source write when both address the same register.
`timescale 1ns/1ps

module register_file #(
    parameter int NUM_SCRATCH = 8
) (
    input  logic                        clk_in,
    input  logic                        rst_n_i,
    input  saturn_alu_pkg::reg_sel_t    src_sel_i,
    input  saturn_alu_pkg::reg_sel_t    dst_sel_i,
    input  saturn_alu_pkg::nib_mask_t   mask_i,
    input  logic                        write_dst_i,
    input  saturn_alu_pkg::word_t       dst_word_i,
    input  logic                        write_src_i,
    input  saturn_alu_pkg::word_t       src_word_i,
    output saturn_alu_pkg::word_t       src_word_o,
    output saturn_alu_pkg::word_t       dst_word_o
);
    import saturn_alu_pkg::*;

    word_t work_q [4];
    word_t scr_q  [NUM_SCRATCH];

    function automatic word_t read_reg(reg_sel_t sel);
        word_t w;
        w = '0;
        if (sel.bank == BANK_WORK)
        begin
            w = work_q[sel.index[1:0]];
        end
        else if (sel.bank == BANK_SCRATCH && int'(sel.index) < NUM_SCRATCH)
        begin
            w = scr_q[sel.index];
        end
        return w;
    endfunction

    function automatic word_t merge_nibbles(word_t old_w, word_t new_w, nib_mask_t m);
        word_t w;
        w = old_w;
        for (int n = 0; n < NIBBLES; n++)
        begin
            if (m[n])
            begin
                w[4*n +: 4] = new_w[4*n +: 4];
            end
        end
        return w;
    endfunction

    assign src_word_o = read_reg(src_sel_i);
    assign dst_word_o = read_reg(dst_sel_i);

    always_ff @(posedge clk_in)
    begin
        if (!rst_n_i)
        begin
            for (int r = 0; r < 4; r++)
            begin
                work_q[r] <= '0;
            end
            for (int r = 0; r < NUM_SCRATCH; r++)
            begin
                scr_q[r] <= '0;
            end
        end
        else
        begin
            for (int r = 0; r < 4; r++)
            begin
                if (write_dst_i && dst_sel_i.bank == BANK_WORK && int'(dst_sel_i.index[1:0]) == r)
                begin
                    work_q[r] <= merge_nibbles(work_q[r], dst_word_i, mask_i);
                end
                else if (write_src_i && src_sel_i.bank == BANK_WORK
                         && int'(src_sel_i.index[1:0]) == r)
                begin
                    work_q[r] <= merge_nibbles(work_q[r], src_word_i, mask_i);
                end
            end
            for (int r = 0; r < NUM_SCRATCH; r++)
            begin
                if (write_dst_i && dst_sel_i.bank == BANK_SCRATCH && int'(dst_sel_i.index) == r)
                begin
                    scr_q[r] <= merge_nibbles(scr_q[r], dst_word_i, mask_i);
                end
                else if (write_src_i && src_sel_i.bank == BANK_SCRATCH
                         && int'(src_sel_i.index) == r)
                begin
                    scr_q[r] <= merge_nibbles(scr_q[r], src_word_i, mask_i);
                end
            end
        end
    end

endmodule

//--- alu_core.sv
// Arithmetic and logic core.
// Latches the masked operands, forms the result and carry of the
// selected operation one cycle later, and keeps the carry and the
// condition flags. Subtract and reverse subtract share one subtractor.
`timescale 1ns/1ps

module alu_core (
    input  logic                     clk_in,
    input  logic                     rst_n_i,
    input  logic                     latch_i,
    input  saturn_alu_pkg::word_t    src_word_i,
    input  saturn_alu_pkg::word_t    dst_word_i,
    input  saturn_alu_pkg::field_t   field_i,
    input  saturn_alu_pkg::alu_op_t  alu_op_i,
    input  logic                     decimal_i,
    input  logic                     forced_carry_i,
    input  logic                     write_carry_i,
    input  logic                     set_carry_i,
    input  logic                     clr_carry_i,
    output saturn_alu_pkg::word_t    result_o,
    output saturn_alu_pkg::word_t    latched_dst_o,
    output logic                     carry_o,
    output logic                     condition_o
);
    import saturn_alu_pkg::*;

    word_t src_q;
    word_t dst_q;
    word_t add_q;
    word_t sub_q;
    word_t sub_a;
    word_t sub_b;
    logic  add_c;
    logic  sub_c;
    logic  op_carry;
    logic  carry_q;
    logic  condition_q;
    logic  cmp_hit;
    logic  relation;
    logic  eq, ne, ge, gt, le, lt;

    always_ff @(posedge clk_in)
    begin
        if (!rst_n_i)
        begin
            src_q <= '0;
            dst_q <= '0;
        end
        else if (latch_i)
        begin
            src_q <= src_word_i;
            dst_q <= dst_word_i;
        end
    end

    // reverse subtract swaps the operands
    assign sub_a = (alu_op_i == OP_RSUB) ? src_q : dst_q;
    assign sub_b = (alu_op_i == OP_RSUB) ? dst_q : src_q;

    bcd_addsub64 u_add (
        .a_i            (dst_q),
        .b_i            (src_q),
        .sub_i          (1'b0),
        .decimal_i      (decimal_i),
        .forced_carry_i (forced_carry_i),
        .field_i        (field_i),
        .q_o            (add_q),
        .carry_o        (add_c)
    );

    bcd_addsub64 u_sub (
        .a_i            (sub_a),
        .b_i            (sub_b),
        .sub_i          (1'b1),
        .decimal_i      (decimal_i),
        .forced_carry_i (forced_carry_i),
        .field_i        (field_i),
        .q_o            (sub_q),
        .carry_o        (sub_c)
    );

    nibble_compare u_cmp (
        .a_i  (dst_q),
        .b_i  (src_q),
        .eq_o (eq),
        .ne_o (ne),
        .ge_o (ge),
        .gt_o (gt),
        .le_o (le),
        .lt_o (lt)
    );

    always_comb
    begin
        result_o = dst_q;   // compares leave the destination as is
        op_carry = 1'b0;
        case (alu_op_i)
            OP_TFR:  result_o = src_q;
            OP_ADD:
            begin
                result_o = add_q;
                op_carry = add_c;
            end
            OP_SUB, OP_RSUB:
            begin
                result_o = sub_q;
                op_carry = sub_c;
            end
            OP_AND:  result_o = src_q & dst_q;
            OP_OR:   result_o = src_q | dst_q;
            OP_SLN:
            begin
                result_o = {src_q[59:0], 4'h0};
                op_carry = src_q[4*field_i.left +: 4] != 4'h0;    // nibble lost at the top
            end
            OP_SRN:
            begin
                result_o = {4'h0, src_q[63:4]};
                op_carry = src_q[4*field_i.right +: 4] != 4'h0;   // nibble lost at the bottom
            end
            OP_CSL:  result_o = {src_q[59:0], src_q[63:60]};
            OP_CSR:  result_o = {src_q[3:0], src_q[63:4]};
            default: result_o = dst_q;
        endcase
    end

    always_comb
    begin
        cmp_hit  = 1'b1;
        relation = eq;
        case (alu_op_i)
            OP_EQ:   relation = eq;
            OP_NE:   relation = ne;
            OP_GE:   relation = ge;
            OP_GT:   relation = gt;
            OP_LE:   relation = le;
            OP_LT:   relation = lt;
            default: cmp_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (!rst_n_i)
        begin
            carry_q     <= 1'b0;
            condition_q <= 1'b0;
        end
        else
        begin
            if (clr_carry_i)
            begin
                carry_q <= 1'b0;
            end
            else if (set_carry_i)
            begin
                carry_q <= 1'b1;
            end
            else if (write_carry_i)
            begin
                carry_q <= op_carry;
            end
            if (cmp_hit)
            begin
                condition_q <= relation;
            end
        end
    end

    assign latched_dst_o = dst_q;
    assign carry_o       = carry_q;
    assign condition_o   = condition_q;

endmodule

//--- saturn_alru.sv
// Arithmetic, logic and register unit of the 64-bit calculator core.
// Selects the source word from the registers or the memory data input,
// masks both operands to the nibble field, runs them through the ALU
// core and writes the result back under the same field mask.
`timescale 1ns/1ps

module saturn_alru #(
    parameter int NUM_SCRATCH = 8
) (
    input  logic                     clk_in,
    input  logic                     rst_n_i,
    input  saturn_alu_pkg::reg_sel_t src_sel_i,
    input  saturn_alu_pkg::reg_sel_t dst_sel_i,
    input  saturn_alu_pkg::field_t   field_i,
    input  saturn_alu_pkg::alu_op_t  alu_op_i,
    input  logic                     decimal_i,
    input  logic                     forced_carry_i,
    input  saturn_alu_pkg::word_t    data_i,
    input  logic                     latch_i,
    input  logic                     write_dst_i,
    input  logic                     write_src_i,
    input  logic                     write_carry_i,
    input  logic                     set_carry_i,
    input  logic                     clr_carry_i,
    output saturn_alu_pkg::word_t    data_o,
    output logic                     carry_o,
    output logic                     condition_o
);
    import saturn_alu_pkg::*;

    word_t     reg_src_word;
    word_t     reg_dst_word;
    word_t     src_word;
    word_t     masked_src;
    word_t     masked_dst;
    word_t     result;
    word_t     latched_dst;
    nib_mask_t field_nibs;

    assign src_word = (src_sel_i.bank == BANK_MEM) ? data_i : reg_src_word;

    register_file #(
        .NUM_SCRATCH (NUM_SCRATCH)
    ) u_regs (
        .clk_in      (clk_in),
        .rst_n_i     (rst_n_i),
        .src_sel_i   (src_sel_i),
        .dst_sel_i   (dst_sel_i),
        .mask_i      (field_nibs),
        .write_dst_i (write_dst_i),
        .dst_word_i  (result),
        .write_src_i (write_src_i),
        .src_word_i  (latched_dst),     // exchange path
        .src_word_o  (reg_src_word),
        .dst_word_o  (reg_dst_word)
    );

    field_mask u_src_mask (
        .field_i (field_i),
        .word_i  (src_word),
        .mask_o  (field_nibs),
        .word_o  (masked_src)
    );

    field_mask u_dst_mask (
        .field_i (field_i),
        .word_i  (reg_dst_word),
        .mask_o  (),
        .word_o  (masked_dst)
    );

    alu_core u_core (
        .clk_in         (clk_in),
        .rst_n_i        (rst_n_i),
        .latch_i        (latch_i),
        .src_word_i     (masked_src),
        .dst_word_i     (masked_dst),
        .field_i        (field_i),
        .alu_op_i       (alu_op_i),
        .decimal_i      (decimal_i),
        .forced_carry_i (forced_carry_i),
        .write_carry_i  (write_carry_i),
        .set_carry_i    (set_carry_i),
        .clr_carry_i    (clr_carry_i),
        .result_o       (result),
        .latched_dst_o  (latched_dst),
        .carry_o        (carry_o),
        .condition_o    (condition_o)
    );

    assign data_o = masked_src;     // memory write data, no latency

endmodule

//--- tb_saturn_alru.sv
// Testbench for the calculator ALU and register unit.
// Runs random transfers, arithmetic, logic, shifts, compares, exchanges
// and carry strobes, and checks registers and flags against a model.
`timescale 1ns/1ps

module tb_saturn_alru;
    import saturn_alu_pkg::*;

    localparam field_t   FULL    = '{left: 4'hf, right: 4'h0};
    localparam reg_sel_t MEM_SEL = '{bank: BANK_MEM, index: 3'd0};

    logic     clk_in;
    logic     rst_n_i;
    reg_sel_t src_sel_i;
    reg_sel_t dst_sel_i;
    field_t   field_i;
    alu_op_t  alu_op_i;
    logic     decimal_i;
    logic     forced_carry_i;
    word_t    data_i;
    logic     latch_i;
    logic     write_dst_i;
    logic     write_src_i;
    logic     write_carry_i;
    logic     set_carry_i;
    logic     clr_carry_i;
    word_t    data_o;
    logic     carry_o;
    logic     condition_o;

    word_t m_work [4];      // model of A..D
    word_t m_scr  [8];      // model of R0..R7
    logic  m_carry;
    logic  m_cond;
    int    n_checks;
    int    n_errors;
    int    test_checks;
    int    test_errors;
    string test_name;

    saturn_alru #(
        .NUM_SCRATCH (8)
    ) DUT (
        .clk_in         (clk_in),
        .rst_n_i        (rst_n_i),
        .src_sel_i      (src_sel_i),
        .dst_sel_i      (dst_sel_i),
        .field_i        (field_i),
        .alu_op_i       (alu_op_i),
        .decimal_i      (decimal_i),
        .forced_carry_i (forced_carry_i),
        .data_i         (data_i),
        .latch_i        (latch_i),
        .write_dst_i    (write_dst_i),
        .write_src_i    (write_src_i),
        .write_carry_i  (write_carry_i),
        .set_carry_i    (set_carry_i),
        .clr_carry_i    (clr_carry_i),
        .data_o         (data_o),
        .carry_o        (carry_o),
        .condition_o    (condition_o)
    );

    always #10 clk_in = ~clk_in;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("error %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("error %s %s: expected %b, actual %b", test_name, name, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    task automatic end_test();
        $display("test %-16s %0d checks, %0d errors", test_name,
                 n_checks - test_checks, n_errors - test_errors);
    endtask

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic word_t rand_bcd();
        word_t w;
        for (int n = 0; n < NIBBLES; n++)
        begin
            w[4*n +: 4] = 4'($urandom % 10);
        end
        return w;
    endfunction

    function automatic field_t rand_field();
        field_t f;
        int     r;
        r       = int'($urandom % 16);
        f.right = nib_t'(r);
        f.left  = nib_t'(r + int'($urandom % (16 - r)));    // never empty
        return f;
    endfunction

    function automatic reg_sel_t rand_sel();
        reg_sel_t s;
        if ($urandom % 2 == 1)
        begin
            s.bank  = BANK_SCRATCH;
            s.index = 3'($urandom % 8);
        end
        else
        begin
            s.bank  = BANK_WORK;
            s.index = 3'($urandom % 4);
        end
        return s;
    endfunction

    function automatic word_t field_word(field_t f);
        word_t m;
        m = '0;
        for (int n = 0; n < NIBBLES; n++)
        begin
            if (n >= int'(f.right) && n <= int'(f.left))
            begin
                m[4*n +: 4] = 4'hf;
            end
        end
        return m;
    endfunction

    function automatic word_t model_read(reg_sel_t sel, word_t mem);
        if (sel.bank == BANK_MEM)
        begin
            return mem;
        end
        else if (sel.bank == BANK_WORK)
        begin
            return m_work[sel.index[1:0]];
        end
        return m_scr[sel.index];
    endfunction

    task automatic model_write(input reg_sel_t sel, input word_t w, input field_t f);
        word_t m;
        m = field_word(f);
        if (sel.bank == BANK_WORK)
        begin
            m_work[sel.index[1:0]] = (m_work[sel.index[1:0]] & ~m) | (w & m);
        end
        else if (sel.bank == BANK_SCRATCH)
        begin
            m_scr[sel.index] = (m_scr[sel.index] & ~m) | (w & m);
        end
    endtask

    // nibble add/subtract over the field from right to left
    task automatic arith_model(input word_t a, input word_t b, input logic sub,
                               input logic dec, input logic fc, input field_t f,
                               output word_t q, output logic c);
        int d;
        q = '0;
        c = fc;
        for (int n = int'(f.right); n <= int'(f.left); n++)
        begin
            if (sub)
            begin
                d = int'(a[4*n +: 4]) - int'(b[4*n +: 4]) - int'(c);
                c = (d < 0);
                if (c)
                begin
                    d = d + 16;
                end
                if (dec && c)
                begin
                    d = (d + 10) % 16;      // minus 6 modulo 16
                end
            end
            else
            begin
                d = int'(a[4*n +: 4]) + int'(b[4*n +: 4]) + int'(c);
                c = dec ? (d > 9) : (d > 15);
                if (dec && c)
                begin
                    d = d + 6;
                end
                d = d % 16;
            end
            q[4*n +: 4] = 4'(d);
        end
    endtask

    task automatic op_model(input alu_op_t op, input word_t ms, input word_t md,
                            input logic dec, input logic fc, input field_t f,
                            output word_t r, output logic c);
        r = md;
        c = 1'b0;
        case (op)
            OP_TFR:  r = ms;
            OP_ADD:  arith_model(md, ms, 1'b0, dec, fc, f, r, c);
            OP_SUB:  arith_model(md, ms, 1'b1, dec, fc, f, r, c);
            OP_RSUB: arith_model(ms, md, 1'b1, dec, fc, f, r, c);
            OP_AND:  r = ms & md;
            OP_OR:   r = ms | md;
            OP_SLN:
            begin
                r = ms << 4;
                c = ms[4*int'(f.left) +: 4] != 4'h0;
            end
            OP_SRN:
            begin
                r = ms >> 4;
                c = ms[4*int'(f.right) +: 4] != 4'h0;
            end
            OP_CSL:  r = (ms << 4) | (ms >> 60);
            OP_CSR:  r = (ms >> 4) | (ms << 60);
            default: r = md;
        endcase
    endtask

    function automatic logic relation(alu_op_t op, word_t md, word_t ms);
        case (op)
            OP_EQ:   return md == ms;
            OP_NE:   return md != ms;
            OP_GE:   return md >= ms;
            OP_GT:   return md > ms;
            OP_LE:   return md <= ms;
            default: return md < ms;
        endcase
    endfunction

    task automatic read_back(input reg_sel_t sel, output word_t w);
        @(negedge clk_in);
        src_sel_i = sel;
        field_i   = FULL;
        alu_op_i  = OP_TFR;
        #5;
        w = data_o;
    endtask

    task automatic verify_reg(input string name, input reg_sel_t sel);
        word_t w;
        read_back(sel, w);
        check_word(name, model_read(sel, '0), w);
    endtask

    // latch cycle, write cycle, then strobes back to idle
    task automatic run_op(input reg_sel_t src, input reg_sel_t dst, input field_t f,
                          input alu_op_t op, input logic dec, input logic fc, input word_t mem,
                          input logic wd, input logic ws, input logic wc, input logic sc,
                          input logic cc, output word_t src_seen);
        @(negedge clk_in);
        src_sel_i      = src;
        dst_sel_i      = dst;
        field_i        = f;
        alu_op_i       = op;
        decimal_i      = dec;
        forced_carry_i = fc;
        data_i         = mem;
        latch_i        = 1'b1;
        #5;
        src_seen = data_o;
        @(negedge clk_in);
        latch_i       = 1'b0;
        write_dst_i   = wd;
        write_src_i   = ws;
        write_carry_i = wc;
        set_carry_i   = sc;
        clr_carry_i   = cc;
        @(negedge clk_in);
        write_dst_i   = 1'b0;
        write_src_i   = 1'b0;
        write_carry_i = 1'b0;
        set_carry_i   = 1'b0;
        clr_carry_i   = 1'b0;
        alu_op_i      = OP_TFR;
    endtask

    task automatic do_op(input string name, input reg_sel_t src, input reg_sel_t dst,
                         input field_t f, input alu_op_t op, input logic dec, input logic fc,
                         input word_t mem, input logic wd, input logic ws, input logic wc,
                         input logic sc, input logic cc);
        word_t ms;
        word_t md;
        word_t r;
        word_t seen;
        logic  c;
        ms = model_read(src, mem) & field_word(f);
        md = model_read(dst, mem) & field_word(f);
        op_model(op, ms, md, dec, fc, f, r, c);
        run_op(src, dst, f, op, dec, fc, mem, wd, ws, wc, sc, cc, seen);
        check_word({name, " data_o"}, ms, seen);
        if (ws)
        begin
            model_write(src, md, f);    // dst write below wins on overlap
        end
        if (wd)
        begin
            model_write(dst, r, f);
        end
        if (cc)
        begin
            m_carry = 1'b0;
        end
        else if (sc)
        begin
            m_carry = 1'b1;
        end
        else if (wc)
        begin
            m_carry = c;
        end
        if (op >= OP_EQ)
        begin
            m_cond = relation(op, md, ms);
        end
        check_flag({name, " carry"}, m_carry, carry_o);
        check_flag({name, " condition"}, m_cond, condition_o);
        if (wd)
        begin
            verify_reg({name, " dst"}, dst);
        end
        if (ws && src.bank != BANK_MEM)
        begin
            verify_reg({name, " src"}, src);
        end
    endtask

    task automatic load_reg(input reg_sel_t sel, input word_t w);
        do_op("load", MEM_SEL, sel, FULL, OP_TFR, 1'b0, 1'b0, w, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_reset();
        word_t w;
        start_test("reset_state");
        for (int r = 0; r < 12; r++)
        begin
            read_back(r < 4 ? reg_sel_t'{BANK_WORK, 3'(r)}
                            : reg_sel_t'{BANK_SCRATCH, 3'(r - 4)}, w);
            check_word("reset register", '0, w);
        end
        check_flag("reset carry", 1'b0, carry_o);
        check_flag("reset condition", 1'b0, condition_o);
        end_test();
    endtask

    task automatic test_mem_load();
        start_test("mem_load");
        for (int i = 0; i < 40; i++)
        begin
            do_op("mem_load", MEM_SEL, rand_sel(), rand_field(), OP_TFR, 1'b0, 1'b0,
                  rand_word(), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        end_test();
    endtask

    task automatic test_arith();
        alu_op_t  op;
        reg_sel_t dst;
        start_test("arithmetic");
        for (int r = 0; r < 12; r++)
        begin
            load_reg(r < 4 ? reg_sel_t'{BANK_WORK, 3'(r)}
                           : reg_sel_t'{BANK_SCRATCH, 3'(r - 4)}, rand_word());
        end
        for (int i = 0; i < 60; i++)
        begin
            op = alu_op_t'(int'(OP_ADD) + int'($urandom % 3));
            do_op("arith_bin", rand_sel(), rand_sel(), rand_field(), op, 1'b0,
                  1'($urandom % 2), rand_word(), 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        end
        for (int i = 0; i < 60; i++)
        begin
            op  = alu_op_t'(int'(OP_ADD) + int'($urandom % 3));
            dst = rand_sel();
            load_reg(dst, rand_bcd());      // decimal operands only
            do_op("arith_dec", MEM_SEL, dst, rand_field(), op, 1'b1,
                  1'($urandom % 2), rand_bcd(), 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        end
        end_test();
    endtask

    task automatic test_logic_shift();
        alu_op_t op;
        start_test("logic_shift");
        for (int i = 0; i < 80; i++)
        begin
            op = alu_op_t'(int'(OP_AND) + int'($urandom % 6));
            do_op("logic_shift", rand_sel(), rand_sel(), rand_field(), op, 1'b0, 1'b0,
                  rand_word(), 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        end
        end_test();
    endtask

    task automatic test_compare();
        alu_op_t  op;
        reg_sel_t sel;
        start_test("compare");
        for (int i = 0; i < 90; i++)
        begin
            op  = alu_op_t'(int'(OP_EQ) + int'($urandom % 6));
            sel = rand_sel();
            if (i % 3 == 2)
            begin
                do_op("compare_equal", sel, sel, rand_field(), op, 1'b0, 1'b0,
                      '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            end
            else
            begin
                do_op("compare_random", rand_sel(), sel, rand_field(), op, 1'b0, 1'b0,
                      '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_exchange_carry();
        start_test("exchange_carry");
        for (int i = 0; i < 30; i++)
        begin
            do_op("exchange", rand_sel(), rand_sel(), rand_field(), OP_TFR, 1'b0, 1'b0,
                  '0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        for (int k = 0; k < 32; k++)
        begin
            do_op("carry_strobes", rand_sel(), rand_sel(), rand_field(), OP_ADD, 1'b0,
                  1'($urandom % 2), '0, 1'b1, 1'b0, k[2], k[0], k[1]);
        end
        end_test();
    endtask

    initial
    begin
        int   t;
        logic released;
        clk_in         = 1'b0;
        rst_n_i        = 1'b0;
        src_sel_i      = MEM_SEL;
        dst_sel_i      = '{BANK_WORK, 3'd0};
        field_i        = FULL;
        alu_op_i       = OP_TFR;
        decimal_i      = 1'b0;
        forced_carry_i = 1'b0;
        data_i         = '0;
        latch_i        = 1'b0;
        write_dst_i    = 1'b0;
        write_src_i    = 1'b0;
        write_carry_i  = 1'b0;
        set_carry_i    = 1'b0;
        clr_carry_i    = 1'b0;
        n_checks       = 0;
        n_errors       = 0;
        m_carry        = 1'b0;
        m_cond         = 1'b0;
        for (int r = 0; r < 4; r++)
        begin
            m_work[r] = '0;
        end
        for (int r = 0; r < 8; r++)
        begin
            m_scr[r] = '0;
        end
        void'($urandom(32'h88ba));
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        rst_n_i  = 1'b1;
        released = 1'b0;
        t        = 0;
        while (!released && t < 20)
        begin
            @(posedge clk_in);
            released = rst_n_i;
            t++;
        end
        if (!released)
        begin
            $display("reset was not released within 20 cycles");
            $display("TESTBENCH FAILED");
        end
        else
        begin
            test_reset();
            test_mem_load();
            test_arith();
            test_logic_shift();
            test_compare();
            test_exchange_carry();
            $display("checks %0d, errors %0d", n_checks, n_errors);
            if (n_errors == 0)
            begin
                $display("TESTBENCH PASSED");
            end
            else
            begin
                $display("TESTBENCH FAILED");
            end
        end
        $finish;
    end

endmodule

//--- sim.f
saturn_alu_pkg.sv
field_mask.sv
bcd_addsub64.sv
nibble_compare.sv
register_file.sv
alu_core.sv
saturn_alru.sv
tb_saturn_alru.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_saturn_alru -o tb_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
